// ==== hdl/sdp_ram.sv ====
module sdp_ram #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 256,
	parameter int AW = $clog2(DEPTH)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  logic we,
	input  logic [AW-1:0] waddr,
	input  logic [AW-1:0] raddr,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// small tables live in flops, so reset clears every row at once
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			rdata <= '0;
		end else begin
			// read sees the old row on a same-cycle write
			if (en) begin
				rdata <= mem[raddr];
			end
			if (we) begin
				mem[waddr] <= wdata;
			end
		end
	end

	a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> int'(waddr) < DEPTH);

endmodule

// ==== hdl/tage_consts.svh ====
`ifndef TAGE_CONSTS_SVH
`define TAGE_CONSTS_SVH

// tagged banks
`define TAGE_BANKS 4
`define TAGE_IDX_W 8
`define TAGE_TAG_W 8
`define TAGE_CTR_W 3
`define TAGE_U_W 2

// bimodal base table
`define TAGE_BASE_IDX_W 10
`define TAGE_BASE_CTR_W 2

// global history and the length each bank sees
`define TAGE_GHIST_W 32
`define TAGE_HIST_LEN0 4
`define TAGE_HIST_LEN1 8
`define TAGE_HIST_LEN2 16
`define TAGE_HIST_LEN3 32

`define TAGE_PC_W 32

`endif

// ==== hdl/tage_history.sv ====
`include "tage_consts.svh"

module tage_history (
	input  logic clk,
	input  logic rst_n,
	input  logic shift_en,
	input  logic taken,
	output tage_pkg::ghist_t ghist,
	output tage_pkg::tage_idx_t [`TAGE_BANKS-1:0] idx_folds,
	output tage_pkg::tage_tag_t [`TAGE_BANKS-1:0] tag_folds1,
	output logic [`TAGE_BANKS-1:0][`TAGE_TAG_W-2:0] tag_folds2
);

	localparam int IDX_W = `TAGE_IDX_W;
	localparam int TAG1_W = `TAGE_TAG_W;
	localparam int TAG2_W = `TAGE_TAG_W - 1;
	localparam int HIST_LEN [`TAGE_BANKS] = '{`TAGE_HIST_LEN0, `TAGE_HIST_LEN1,
		`TAGE_HIST_LEN2, `TAGE_HIST_LEN3};

	tage_pkg::tage_idx_t [`TAGE_BANKS-1:0] idx_next;
	tage_pkg::tage_tag_t [`TAGE_BANKS-1:0] tag1_next;
	logic [`TAGE_BANKS-1:0][TAG2_W-1:0] tag2_next;

	// rotate by one, new bit in at 0, drop the bit leaving the bank's window
	for (genvar b = 0; b < `TAGE_BANKS; b++) begin : g_fold
		localparam int LEN = HIST_LEN[b];
		logic old_bit;

		assign old_bit = ghist[LEN-1];
		assign idx_next[b] = {idx_folds[b][IDX_W-2:0], idx_folds[b][IDX_W-1] ^ taken}
			^ (IDX_W'(old_bit) << (LEN % IDX_W));
		assign tag1_next[b] = {tag_folds1[b][TAG1_W-2:0], tag_folds1[b][TAG1_W-1] ^ taken}
			^ (TAG1_W'(old_bit) << (LEN % TAG1_W));
		assign tag2_next[b] = {tag_folds2[b][TAG2_W-2:0], tag_folds2[b][TAG2_W-1] ^ taken}
			^ (TAG2_W'(old_bit) << (LEN % TAG2_W));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ghist <= '0;
			idx_folds <= '0;
			tag_folds1 <= '0;
			tag_folds2 <= '0;
		end else if (shift_en) begin
			ghist <= {ghist[`TAGE_GHIST_W-2:0], taken};
			idx_folds <= idx_next;
			tag_folds1 <= tag1_next;
			tag_folds2 <= tag2_next;
		end
	end

endmodule

// ==== hdl/tage_index_hash.sv ====
`include "tage_consts.svh"

module tage_index_hash #(
	parameter int BANK = 0
) (
	input  tage_pkg::pc_t pc,
	input  tage_pkg::tage_idx_t idx_fold,
	input  tage_pkg::tage_tag_t tag_fold1,
	input  logic [`TAGE_TAG_W-2:0] tag_fold2,
	output tage_pkg::tage_idx_t idx,
	output tage_pkg::tage_tag_t tag
);

	localparam int SHIFT = 10 + BANK;

	tage_pkg::pc_t pc_shr;
	tage_pkg::tage_idx_t pc_lo;
	tage_pkg::tage_tag_t fold2_shl;

	// word address bits, byte offset dropped
	assign pc_lo = pc[`TAGE_IDX_W+1:2];

	// each bank mixes in a different slice of the upper pc
	assign pc_shr = pc >> SHIFT;

	assign idx = pc_lo ^ pc_shr[`TAGE_IDX_W-1:0] ^ idx_fold;

	// second fold is one bit narrower
	assign fold2_shl = {tag_fold2, 1'b0};

	assign tag = pc_lo ^ tag_fold1 ^ fold2_shl;

endmodule

// ==== hdl/tage_pkg.sv ====
`include "tage_consts.svh"

package tage_pkg;

	typedef logic [`TAGE_PC_W-1:0] pc_t;
	typedef logic [`TAGE_IDX_W-1:0] tage_idx_t;
	typedef logic [`TAGE_TAG_W-1:0] tage_tag_t;
	typedef logic [`TAGE_CTR_W-1:0] tage_ctr_t;
	typedef logic [`TAGE_U_W-1:0] tage_u_t;
	typedef logic [`TAGE_BASE_IDX_W-1:0] base_idx_t;
	typedef logic [`TAGE_BASE_CTR_W-1:0] base_ctr_t;
	typedef logic [`TAGE_GHIST_W-1:0] ghist_t;

	typedef struct packed {
		tage_tag_t tag;
		tage_ctr_t ctr;
		tage_u_t u;
	} tage_entry_t;

	// one lookup, handed back at resolve
	typedef struct packed {
		tage_idx_t [`TAGE_BANKS-1:0] idx;
		tage_tag_t [`TAGE_BANKS-1:0] tag;
		// stored tag of each row read, kept so a u decay rewrites it unchanged
		tage_tag_t [`TAGE_BANKS-1:0] rd_tag;
		logic [`TAGE_BANKS-1:0] hit;
		logic [`TAGE_BANKS-1:0] u_nz;
		tage_ctr_t [`TAGE_BANKS-1:0] ctr;
		tage_u_t [`TAGE_BANKS-1:0] u;
		logic provider_hit;
		logic [1:0] provider;
		base_idx_t base_idx;
		base_ctr_t base_ctr;
		logic pred_taken;
		logic base_taken;
	} tage_meta_t;

endpackage

// ==== hdl/tage_predictor.sv ====
`include "tage_consts.svh"

module tage_predictor (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup_valid,
	input  tage_pkg::pc_t lookup_pc,
	input  logic stall,
	output logic pred_valid,
	output logic pred_taken,
	output tage_pkg::tage_meta_t pred_meta,
	input  logic resolve_valid,
	input  logic resolve_taken,
	input  tage_pkg::tage_meta_t resolve_meta
);

	localparam int BANKS = `TAGE_BANKS;

	logic rd_en;
	tage_pkg::ghist_t ghist;
	tage_pkg::tage_idx_t [BANKS-1:0] idx_folds;
	tage_pkg::tage_tag_t [BANKS-1:0] tag_folds1;
	logic [BANKS-1:0][`TAGE_TAG_W-2:0] tag_folds2;
	tage_pkg::tage_idx_t [BANKS-1:0] lk_idx;
	tage_pkg::tage_idx_t [BANKS-1:0] idx_q;
	tage_pkg::tage_tag_t [BANKS-1:0] lk_tag;
	tage_pkg::tage_tag_t [BANKS-1:0] tag_q;
	logic [BANKS-1:0] hit;
	logic [BANKS-1:0] u_nz;
	logic [BANKS-1:0] bank_taken;
	logic [BANKS-1:0] bank_we;
	tage_pkg::tage_idx_t [BANKS-1:0] bank_widx;
	tage_pkg::tage_entry_t [BANKS-1:0] entry;
	tage_pkg::tage_entry_t [BANKS-1:0] bank_wentry;
	tage_pkg::base_idx_t base_idx_q;
	tage_pkg::base_ctr_t base_ctr;
	tage_pkg::base_ctr_t base_wctr;
	logic base_we;
	logic provider_hit;
	logic [1:0] provider;

	// stall freezes every read port
	assign rd_en = lookup_valid && !stall;

	tage_history u_history (
		.clk(clk),
		.rst_n(rst_n),
		.shift_en(resolve_valid),
		.taken(resolve_taken),
		.ghist(ghist),
		.idx_folds(idx_folds),
		.tag_folds1(tag_folds1),
		.tag_folds2(tag_folds2)
	);

	for (genvar b = 0; b < BANKS; b++) begin : g_bank
		tage_index_hash #(
			.BANK(b)
		) u_hash (
			.pc(lookup_pc),
			.idx_fold(idx_folds[b]),
			.tag_fold1(tag_folds1[b]),
			.tag_fold2(tag_folds2[b]),
			.idx(lk_idx[b]),
			.tag(lk_tag[b])
		);

		tage_table u_table (
			.clk(clk),
			.rst_n(rst_n),
			.en(rd_en),
			.lookup_idx(lk_idx[b]),
			.lookup_tag(lk_tag[b]),
			.we(bank_we[b]),
			.wr_idx(bank_widx[b]),
			.wr_entry(bank_wentry[b]),
			.hit(hit[b]),
			.u_nz(u_nz[b]),
			.taken(bank_taken[b]),
			.entry(entry[b])
		);
	end

	sdp_ram #(
		.WIDTH(`TAGE_BASE_CTR_W),
		.DEPTH(1 << `TAGE_BASE_IDX_W)
	) u_base (
		.clk(clk),
		.rst_n(rst_n),
		.en(rd_en),
		.we(base_we),
		.waddr(resolve_meta.base_idx),
		.raddr(lookup_pc[`TAGE_BASE_IDX_W+1:2]),
		.wdata(base_wctr),
		.rdata(base_ctr)
	);

	tage_update u_update (
		.resolve_valid(resolve_valid),
		.resolve_taken(resolve_taken),
		.meta(resolve_meta),
		.bank_we(bank_we),
		.bank_widx(bank_widx),
		.bank_wentry(bank_wentry),
		.base_we(base_we),
		.base_wctr(base_wctr)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pred_valid <= 1'b0;
		end else if (!stall) begin
			pred_valid <= lookup_valid;
		end
	end

	// lookup stage record aligned with the RAM read data
	always_ff @(posedge clk) begin
		if (rd_en) begin
			idx_q <= lk_idx;
			tag_q <= lk_tag;
			base_idx_q <= lookup_pc[`TAGE_BASE_IDX_W+1:2];
		end
	end

	// longest history hit provides
	always_comb begin
		provider_hit = 1'b0;
		provider = '0;
		for (int b = 0; b < BANKS; b++) begin
			if (hit[b]) begin
				provider_hit = 1'b1;
				provider = 2'(b);
			end
		end
	end

	assign pred_taken = provider_hit ? bank_taken[provider] : base_ctr[`TAGE_BASE_CTR_W-1];

	always_comb begin
		pred_meta.idx = idx_q;
		pred_meta.tag = tag_q;
		pred_meta.hit = hit;
		pred_meta.u_nz = u_nz;
		for (int b = 0; b < BANKS; b++) begin
			pred_meta.rd_tag[b] = entry[b].tag;
			pred_meta.ctr[b] = entry[b].ctr;
			pred_meta.u[b] = entry[b].u;
		end
		pred_meta.provider_hit = provider_hit;
		pred_meta.provider = provider;
		pred_meta.base_idx = base_idx_q;
		pred_meta.base_ctr = base_ctr;
		pred_meta.pred_taken = pred_taken;
		pred_meta.base_taken = base_ctr[`TAGE_BASE_CTR_W-1];
	end

	// incremental fold of the longest bank matches a full fold of the history
	a_fold_match: assert property (@(posedge clk) disable iff (!rst_n)
		idx_folds[BANKS-1] == (ghist[7:0] ^ ghist[15:8] ^ ghist[23:16] ^ ghist[31:24]));

	// returned record flags a provider exactly when some bank hit
	a_meta_provider: assert property (@(posedge clk) disable iff (!rst_n)
		resolve_valid |-> resolve_meta.provider_hit == (resolve_meta.hit != '0));

	// a new entry never lands on the provider or any other bank that hit
	a_alloc_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
		resolve_valid |-> (u_update.alloc_we & resolve_meta.hit) == '0);

endmodule

// ==== hdl/tage_table.sv ====
`include "tage_consts.svh"

module tage_table (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  tage_pkg::tage_idx_t lookup_idx,
	input  tage_pkg::tage_tag_t lookup_tag,
	input  logic we,
	input  tage_pkg::tage_idx_t wr_idx,
	input  tage_pkg::tage_entry_t wr_entry,
	output logic hit,
	output logic u_nz,
	output logic taken,
	output tage_pkg::tage_entry_t entry
);

	tage_pkg::tage_tag_t match_tag;

	// tag follows the row into the read stage
	always_ff @(posedge clk) begin
		if (en) begin
			match_tag <= lookup_tag;
		end
	end

	sdp_ram #(
		.WIDTH($bits(tage_pkg::tage_entry_t)),
		.DEPTH(1 << `TAGE_IDX_W)
	) u_ram (
		.clk(clk),
		.rst_n(rst_n),
		.en(en),
		.we(we),
		.waddr(wr_idx),
		.raddr(lookup_idx),
		.wdata(wr_entry),
		.rdata(entry)
	);

	assign hit = entry.tag == match_tag;
	assign u_nz = entry.u != '0;
	assign taken = entry.ctr[`TAGE_CTR_W-1];

endmodule

// ==== hdl/tage_update.sv ====
`include "tage_consts.svh"

module tage_update (
	input  logic resolve_valid,
	input  logic resolve_taken,
	input  tage_pkg::tage_meta_t meta,
	output logic [`TAGE_BANKS-1:0] bank_we,
	output tage_pkg::tage_idx_t [`TAGE_BANKS-1:0] bank_widx,
	output tage_pkg::tage_entry_t [`TAGE_BANKS-1:0] bank_wentry,
	output logic base_we,
	output tage_pkg::base_ctr_t base_wctr
);

	localparam int BANKS = `TAGE_BANKS;

	logic mispred;
	logic [BANKS-1:0] above;
	logic [BANKS-1:0] cand;
	logic [BANKS-1:0] prov_we;
	logic [BANKS-1:0] alloc_we;
	logic [BANKS-1:0] decay_we;
	tage_pkg::tage_ctr_t weak_ctr;

	function automatic tage_pkg::tage_ctr_t ctr_step(tage_pkg::tage_ctr_t c, logic t);
		if (t && c != '1) begin
			return c + 1'b1;
		end else if (!t && c != '0) begin
			return c - 1'b1;
		end
		return c;
	endfunction

	function automatic tage_pkg::base_ctr_t base_step(tage_pkg::base_ctr_t c, logic t);
		if (t && c != '1) begin
			return c + 1'b1;
		end else if (!t && c != '0) begin
			return c - 1'b1;
		end
		return c;
	endfunction

	function automatic tage_pkg::tage_u_t u_step(tage_pkg::tage_u_t u, logic up);
		if (up && u != '1) begin
			return u + 1'b1;
		end else if (!up && u != '0) begin
			return u - 1'b1;
		end
		return u;
	endfunction

	assign mispred = meta.pred_taken != resolve_taken;

	// allocation window, every bank when nothing hit
	always_comb begin
		above = '0;
		for (int b = 0; b < BANKS; b++) begin
			if (!meta.provider_hit || b > meta.provider) begin
				above[b] = 1'b1;
			end
		end
	end

	assign cand = above & ~meta.u_nz;

	// lowest free bank wins; if none, age everything above the provider
	assign alloc_we = (resolve_valid && mispred) ? (cand & (~cand + 1'b1)) : '0;
	assign decay_we = (resolve_valid && mispred && cand == '0) ? above : '0;
	assign prov_we = (resolve_valid && meta.provider_hit) ? (BANKS'(1) << meta.provider) : '0;
	assign bank_we = prov_we | alloc_we | decay_we;

	assign weak_ctr = resolve_taken ? tage_pkg::tage_ctr_t'(4) : tage_pkg::tage_ctr_t'(3);

	always_comb begin
		for (int b = 0; b < BANKS; b++) begin
			bank_widx[b] = meta.idx[b];
			bank_wentry[b].tag = meta.rd_tag[b];
			bank_wentry[b].ctr = meta.ctr[b];
			bank_wentry[b].u = u_step(meta.u[b], 1'b0);
			if (prov_we[b]) begin
				bank_wentry[b].ctr = ctr_step(meta.ctr[b], resolve_taken);
				bank_wentry[b].u = meta.u[b];
				// u only moves when the provider overrode the base
				if (meta.pred_taken != meta.base_taken) begin
					bank_wentry[b].u = u_step(meta.u[b], !mispred);
				end
			end else if (alloc_we[b]) begin
				bank_wentry[b].tag = meta.tag[b];
				bank_wentry[b].ctr = weak_ctr;
				bank_wentry[b].u = '0;
			end
		end
	end

	assign base_we = resolve_valid && !meta.provider_hit;
	assign base_wctr = base_step(meta.base_ctr, resolve_taken);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the TAGE predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tage_tb -f src.f -o tage_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tage_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
exit 1

// ==== src.f ====
+incdir+hdl
+incdir+test
hdl/tage_pkg.sv
hdl/sdp_ram.sv
hdl/tage_index_hash.sv
hdl/tage_history.sv
hdl/tage_table.sv
hdl/tage_update.sv
hdl/tage_predictor.sv
test/tage_tb.sv

// ==== test/tage_model.svh ====
`ifndef TAGE_MODEL_SVH
`define TAGE_MODEL_SVH

tage_pkg::base_ctr_t m_base [1 << `TAGE_BASE_IDX_W];
tage_pkg::tage_entry_t m_bank [`TAGE_BANKS][1 << `TAGE_IDX_W];
tage_pkg::ghist_t m_hist;

function automatic void clear_model();
	for (int i = 0; i < (1 << `TAGE_BASE_IDX_W); i++) begin
		m_base[i] = '0;
	end
	for (int b = 0; b < `TAGE_BANKS; b++) begin
		for (int i = 0; i < (1 << `TAGE_IDX_W); i++) begin
			m_bank[b][i] = '0;
		end
	end
	m_hist = '0;
endfunction

function automatic int hist_len(int b);
	case (b)
		0: return `TAGE_HIST_LEN0;
		1: return `TAGE_HIST_LEN1;
		2: return `TAGE_HIST_LEN2;
		default: return `TAGE_HIST_LEN3;
	endcase
endfunction

// full fold, history bit i lands at i mod w
function automatic logic [7:0] fold_hist(tage_pkg::ghist_t h, int len, int w);
	logic [7:0] f;
	f = '0;
	for (int i = 0; i < len; i++) begin
		f[i % w] = f[i % w] ^ h[i];
	end
	return f;
endfunction

function automatic int sat_move(int v, logic up, int top);
	if (up) begin
		return (v < top) ? v + 1 : v;
	end
	return (v > 0) ? v - 1 : v;
endfunction

function automatic tage_pkg::tage_meta_t expect_lookup(tage_pkg::pc_t pc);
	tage_pkg::tage_meta_t m;
	tage_pkg::pc_t shr;
	tage_pkg::tage_entry_t e;
	logic [7:0] lo;
	logic [7:0] f1;
	logic [7:0] f2;
	m = '0;
	lo = pc[9:2];
	for (int b = 0; b < `TAGE_BANKS; b++) begin
		shr = pc >> (10 + b);
		f1 = fold_hist(m_hist, hist_len(b), 8);
		f2 = fold_hist(m_hist, hist_len(b), 7);
		m.idx[b] = lo ^ shr[7:0] ^ f1;
		m.tag[b] = lo ^ f1 ^ {f2[6:0], 1'b0};
		e = m_bank[b][m.idx[b]];
		m.rd_tag[b] = e.tag;
		m.ctr[b] = e.ctr;
		m.u[b] = e.u;
		m.u_nz[b] = e.u != '0;
		m.hit[b] = e.tag == m.tag[b];
		// highest hitting bank wins
		if (m.hit[b]) begin
			m.provider_hit = 1'b1;
			m.provider = 2'(b);
		end
	end
	m.base_idx = pc[11:2];
	m.base_ctr = m_base[m.base_idx];
	m.base_taken = m.base_ctr[1];
	m.pred_taken = m.provider_hit ? m.ctr[m.provider][2] : m.base_taken;
	return m;
endfunction

function automatic void train_model(tage_pkg::tage_meta_t m, logic t);
	tage_pkg::tage_entry_t e;
	logic miss;
	logic found;
	int p;
	miss = m.pred_taken != t;
	p = m.provider_hit ? int'(m.provider) : -1;
	if (!m.provider_hit) begin
		m_base[m.base_idx] = tage_pkg::base_ctr_t'(sat_move(int'(m.base_ctr), t, 3));
	end else begin
		e.tag = m.rd_tag[p];
		e.ctr = tage_pkg::tage_ctr_t'(sat_move(int'(m.ctr[p]), t, 7));
		e.u = m.u[p];
		if (m.pred_taken != m.base_taken) begin
			e.u = tage_pkg::tage_u_t'(sat_move(int'(m.u[p]), !miss, 3));
		end
		m_bank[p][m.idx[p]] = e;
	end
	if (miss) begin
		found = 1'b0;
		for (int b = p + 1; b < `TAGE_BANKS; b++) begin
			if (!found && m.u[b] == '0) begin
				found = 1'b1;
				e.tag = m.tag[b];
				e.ctr = t ? 3'd4 : 3'd3;
				e.u = '0;
				m_bank[b][m.idx[b]] = e;
			end
		end
		// nothing free, age the whole window
		for (int b = p + 1; b < `TAGE_BANKS; b++) begin
			if (!found) begin
				e.tag = m.rd_tag[b];
				e.ctr = m.ctr[b];
				e.u = tage_pkg::tage_u_t'(sat_move(int'(m.u[b]), 1'b0, 3));
				m_bank[b][m.idx[b]] = e;
			end
		end
	end
	m_hist = {m_hist[`TAGE_GHIST_W-2:0], t};
endfunction

`endif

// ==== test/tage_tb.sv ====
`include "tage_consts.svh"

module tage_tb;

	localparam int ROWS = 240;
	localparam int HOLD_CYCLES = 2;

	typedef logic [159:0] wide_t;

	typedef struct packed {
		tage_pkg::pc_t pc;
		logic taken;
		logic stall;
		logic resolve;
	} row_t;

	logic clk;
	logic rst_n;
	logic lookup_valid;
	tage_pkg::pc_t lookup_pc;
	logic stall;
	logic pred_valid;
	logic pred_taken;
	tage_pkg::tage_meta_t pred_meta;
	logic resolve_valid;
	logic resolve_taken;
	tage_pkg::tage_meta_t resolve_meta;

	row_t rows [ROWS];
	tage_pkg::tage_meta_t row_exp [ROWS];
	int n_rows;
	int checks;
	int errors;
	int preds;
	logic [31:0] lfsr;

	`include "tage_model.svh"

	tage_predictor i_tage_predictor (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_valid(lookup_valid),
		.lookup_pc(lookup_pc),
		.stall(stall),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken),
		.pred_meta(pred_meta),
		.resolve_valid(resolve_valid),
		.resolve_taken(resolve_taken),
		.resolve_meta(resolve_meta)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#((ROWS + 16) * 4 * 10);
		$display("watchdog expired before the stimulus table finished");
		$display("TEST FAIL");
		$finish;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic add_row(tage_pkg::pc_t pc, logic taken, logic stl, logic res);
		if (n_rows < ROWS) begin
			rows[n_rows].pc = pc;
			rows[n_rows].taken = taken;
			rows[n_rows].stall = stl;
			rows[n_rows].resolve = res;
			n_rows++;
		end
	endtask

	task automatic build_table();
		tage_pkg::pc_t pc_r;
		logic [31:0] t_r;
		n_rows = 0;
		// always taken so the base trains and history fills with ones
		for (int i = 0; i < 40; i++) begin
			add_row(32'h0000_1040, 1'b1, 1'b0, 1'b1);
		end
		// cold branch misses and then comes back under the same history
		add_row(32'h0000_3a80, 1'b1, 1'b0, 1'b1);
		add_row(32'h0000_0500, 1'b0, 1'b0, 1'b0);
		add_row(32'h0000_3a80, 1'b1, 1'b0, 1'b1);
		// two interleaved alternating branches
		for (int i = 0; i < 24; i++) begin
			add_row(32'h0000_2468, 1'(i % 2), 1'b0, 1'b1);
			add_row(32'h0000_1358, 1'((i / 2) % 2), 1'b0, 1'b1);
		end
		// back to back lookups with two of them stalled
		for (int i = 0; i < 6; i++) begin
			add_row(32'h0000_4000 + 32'(i * 4), 1'b0, i == 2 || i == 4, 1'b0);
		end
		add_row(32'h0000_2468, 1'b1, 1'b1, 1'b1);
		while (n_rows < ROWS) begin
			pc_r = 32'h0001_0000 | (lfsr_bits(7) << 2);
			t_r = lfsr_bits(1);
			add_row(pc_r, t_r[0], 1'b0, 1'b1);
		end
	endtask

	// lookup of row r sees the tables before row r-1 is resolved
	task automatic fill_expected();
		clear_model();
		for (int r = 0; r < ROWS; r++) begin
			row_exp[r] = expect_lookup(rows[r].pc);
			if (r > 0 && rows[r-1].resolve) begin
				train_model(row_exp[r-1], rows[r-1].taken);
			end
		end
	endtask

	task automatic check_eq(string name, wide_t got, wide_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at time %0t: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic finish_row(int r);
		check_eq("pred_valid", wide_t'(pred_valid), wide_t'(1'b1));
		check_eq("pred_taken", wide_t'(pred_taken), wide_t'(row_exp[r].pred_taken));
		check_eq("pred_meta", wide_t'(pred_meta), wide_t'(row_exp[r]));
		if (pred_valid) begin
			preds++;
		end
		if (rows[r].stall) begin
			for (int k = 0; k < HOLD_CYCLES; k++) begin
				stall = 1'b1;
				lookup_valid = 1'b1;
				lookup_pc = rows[r].pc ^ 32'h0000_0ff0;
				@(negedge clk);
				check_eq("pred_valid", wide_t'(pred_valid), wide_t'(1'b1));
				check_eq("pred_taken", wide_t'(pred_taken), wide_t'(row_exp[r].pred_taken));
				check_eq("pred_meta", wide_t'(pred_meta), wide_t'(row_exp[r]));
			end
			stall = 1'b0;
			lookup_valid = 1'b0;
		end
		if (rows[r].resolve) begin
			resolve_valid = 1'b1;
			resolve_taken = rows[r].taken;
			resolve_meta = pred_meta;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		lookup_valid = 1'b0;
		lookup_pc = '0;
		stall = 1'b0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		resolve_meta = '0;
		checks = 0;
		errors = 0;
		preds = 0;
		lfsr = 32'h0c859448;
		build_table();
		fill_expected();
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_eq("pred_valid", wide_t'(pred_valid), '0);
		for (int r = 0; r < ROWS; r++) begin
			@(negedge clk);
			resolve_valid = 1'b0;
			if (r > 0) begin
				finish_row(r - 1);
			end
			lookup_valid = 1'b1;
			lookup_pc = rows[r].pc;
		end
		@(negedge clk);
		resolve_valid = 1'b0;
		lookup_valid = 1'b0;
		finish_row(ROWS - 1);
		@(negedge clk);
		resolve_valid = 1'b0;
		check_eq("pred_valid", wide_t'(pred_valid), '0);
		check_eq("prediction count", wide_t'(preds), wide_t'(ROWS));
		$display("checks %0d, errors %0d, predictions %0d of %0d", checks, errors, preds, ROWS);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
